// ==== common/ieu_cfg_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IEU sizes
// Data, address and register-index widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package ieu_cfg_pkg;

   // Base widths
   localparam int DW      = 32;            // Data path width
   localparam int AW      = 32;            // Byte address width
   localparam int REG_AW  = 5;             // Register file index

   // Derived from the above
   localparam int PC_W    = AW - 2;        // Word-aligned pc, low 2 bits dropped
   localparam int BE_W    = DW / 8;        // Byte lanes in one data word
   localparam int LANE_AW = $clog2(BE_W);  // Byte offset inside a word

endpackage

// ==== common/ieu_op_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IEU formats
// Opcodes, issue packet, data bus and result records
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package ieu_op_pkg;

   import ieu_cfg_pkg::*;

   // Arithmetic unit ops
   typedef enum logic [1:0] {
      AU_ADD = 2'd0,
      AU_SUB = 2'd1,
      AU_MUL = 2'd2                   // Low half of product only
   } au_opc_e;

   // Logic unit ops
   typedef enum logic [2:0] {
      LU_AND = 3'd0,
      LU_OR  = 3'd1,
      LU_XOR = 3'd2,
      LU_SLL = 3'd3,
      LU_SRL = 3'd4,
      LU_SRA = 3'd5
   } lu_opc_e;

   // Result producer
   typedef enum logic [1:0] {
      FU_NONE = 2'd0,
      FU_AU   = 2'd1,
      FU_LU   = 2'd2,
      FU_MU   = 2'd3
   } fu_e;

   // Access width, coded as byte count
   typedef enum logic [2:0] {
      SZ_BYTE = 3'd1,
      SZ_HALF = 3'd2,
      SZ_WORD = 3'd4
   } mem_size_e;

   // One opcode field, two readings depending on fu
   typedef union packed {
      struct packed {
         logic    rsvd;               // Pad to LU width
         au_opc_e opc;
      } au;
      lu_opc_e lu;
   } opc_u;

   typedef struct packed {
      logic [DW-1:0]     op1;
      logic [DW-1:0]     op2;
      logic [DW-1:0]     op3;         // Store data
      fu_e               fu;
      opc_u              opc;
      logic              mem_load;
      logic              mem_store;
      mem_size_e         mem_size;
      logic              wb_regf;
      logic [REG_AW-1:0] wb_reg_addr;
      logic [PC_W-1:0]   insn_pc;
      logic              jmplink;
      logic              specul_jmprel;
      logic              specul_jmpfar;
      logic              specul_bcc;  // Predicted taken
      logic [PC_W-1:0]   specul_tgt;
   } issue_t;

   typedef struct packed {
      logic [AW-1:0] addr;
      logic [DW-1:0] wdata;          // Already in its byte lanes
      mem_size_e     size;
      logic          we;
   } dbus_req_t;

   typedef struct packed {
      logic [REG_AW-1:0] addr;
      logic [DW-1:0]     data;
   } regf_wr_t;

   typedef struct packed {
      logic            jmprel;
      logic [PC_W-1:0] insn_pc;
      logic            hit;
   } bpu_upd_t;

endpackage

// ==== hdl/ieu_au.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arithmetic unit
// Add, subtract and low-half multiply
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module ieu_au
   import ieu_cfg_pkg::*, ieu_op_pkg::*;
(
   input  logic [DW-1:0] op1_i,
   input  logic [DW-1:0] op2_i,
   input  au_opc_e       opc_i,
   output logic [DW-1:0] res_o
);

   logic [DW-1:0] sum;
   logic [DW-1:0] diff;
   logic [DW-1:0] prod;

   assign sum  = op1_i + op2_i;
   assign diff = op1_i - op2_i;

   // Truncated to DW bits, upper half never needed
   assign prod = op1_i * op2_i;

   // Result mux
   always_comb begin
      case (opc_i)
         AU_ADD:  res_o = sum;
         AU_SUB:  res_o = diff;
         AU_MUL:  res_o = prod;
         default: res_o = '0;         // Unused code
      endcase
   end

endmodule

// ==== hdl/ieu_lu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Logic unit
// Bitwise ops and the three shifts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module ieu_lu
   import ieu_cfg_pkg::*, ieu_op_pkg::*;
(
   input  logic [DW-1:0] op1_i,
   input  logic [DW-1:0] op2_i,
   input  lu_opc_e       opc_i,
   output logic [DW-1:0] res_o
);

   localparam int SH_W = $clog2(DW);  // 5 bits for a 32-bit word

   logic [SH_W-1:0] shamt;
   logic [DW-1:0]   sra_res;

   assign shamt = op2_i[SH_W-1:0];    // Upper bits of op2 ignored

   // Sign fill from op1 msb
   assign sra_res = DW'($signed(op1_i) >>> shamt);

   always_comb begin
      case (opc_i)
         LU_AND:  res_o = op1_i & op2_i;
         LU_OR:   res_o = op1_i | op2_i;
         LU_XOR:  res_o = op1_i ^ op2_i;
         LU_SLL:  res_o = op1_i << shamt;
         LU_SRL:  res_o = op1_i >> shamt;   // Zero fill
         LU_SRA:  res_o = sra_res;
         default: res_o = '0;
      endcase
   end

endmodule

// ==== ieu/ieu_mu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory unit
// Load/store sequencer, one access in flight
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module ieu_mu
   import ieu_cfg_pkg::*, ieu_op_pkg::*;
(
   input  logic          clk,
   input  logic          rst_i,
   input  logic          start_i,          // Memory insn valid at issue
   input  issue_t        issue_i,
   output logic          dbus_req_valid_o,
   output dbus_req_t     dbus_req_o,
   input  logic          dbus_req_ready_i,
   input  logic          dbus_resp_valid_i,
   input  logic [DW-1:0] dbus_resp_data_i,
   output logic          done_o,           // Response cycle
   output logic [DW-1:0] load_data_o
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_REQ,                                 // Request held on bus
      S_WAIT                                 // Accepted, waiting for data
   } state_e;

   state_e          state_q;
   state_e          state_d;
   dbus_req_t       req_q;
   logic [AW-1:0]   addr;
   logic [DW-1:0]   wdata;
   logic [DW-1:0]   rdata;

   // Effective address
   assign addr  = issue_i.op1 + issue_i.op2;

   // Store data moved up into its byte lanes
   assign wdata = issue_i.op3 << {addr[LANE_AW-1:0], 3'b000};

   always_comb begin
      state_d = state_q;
      case (state_q)
         S_IDLE:  if (start_i) state_d = S_REQ;
         S_REQ:   if (dbus_req_ready_i) state_d = S_WAIT;
         S_WAIT:  if (dbus_resp_valid_i) state_d = S_IDLE;
         default: state_d = S_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_i) state_q <= S_IDLE;
      else       state_q <= state_d;
   end

   // Request captured once, stable until accepted
   always_ff @(posedge clk) begin
      if (state_q == S_IDLE && start_i) begin
         req_q.addr  <= addr;
         req_q.wdata <= wdata;
         req_q.size  <= issue_i.mem_size;
         req_q.we    <= issue_i.mem_store;
      end
   end

   assign dbus_req_valid_o = (state_q == S_REQ);
   assign dbus_req_o       = req_q;
   assign done_o           = (state_q == S_WAIT) & dbus_resp_valid_i;

   // Addressed lanes down to bit 0
   assign rdata = dbus_resp_data_i >> {req_q.addr[LANE_AW-1:0], 3'b000};

   always_comb begin
      case (req_q.size)
         SZ_BYTE: load_data_o = {{(DW-8){1'b0}}, rdata[7:0]};
         SZ_HALF: load_data_o = {{(DW-16){1'b0}}, rdata[15:0]};
         default: load_data_o = rdata;       // Full word
      endcase
   end

endmodule

// ==== ieu/ieu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer execution stage
// Units, write-back select and branch check
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module ieu
   import ieu_cfg_pkg::*, ieu_op_pkg::*;
(
   input  logic            clk,
   input  logic            rst_i,
   input  logic            issue_valid_i,
   input  issue_t          issue_i,
   output logic            issue_ready_o,
   input  logic            msr_psr_cc_i,     // Real branch condition
   output logic            regf_we_o,
   output regf_wr_t        regf_wr_o,
   output logic            flush_o,
   output logic [PC_W-1:0] flush_tgt_o,
   output logic            bpu_upd_valid_o,
   output bpu_upd_t        bpu_upd_o,
   output logic            dbus_req_valid_o,
   output dbus_req_t       dbus_req_o,
   input  logic            dbus_req_ready_i,
   input  logic            dbus_resp_valid_i,
   input  logic [DW-1:0]   dbus_resp_data_i
);

   logic [DW-1:0] au_res;
   logic [DW-1:0] lu_res;
   logic [DW-1:0] mu_load_data;
   logic [DW-1:0] link_addr;
   logic [DW-1:0] wb_data;
   logic          is_mem;
   logic          is_branch;
   logic          mu_done;
   logic          commit;
   logic          mispredict;

   assign is_mem    = issue_i.mem_load | issue_i.mem_store;
   assign is_branch = issue_i.specul_jmprel | issue_i.specul_jmpfar;

   ieu_au au (
      .op1_i (issue_i.op1),
      .op2_i (issue_i.op2),
      .opc_i (issue_i.opc.au.opc),           // AU view of opcode
      .res_o (au_res)
   );

   ieu_lu lu (
      .op1_i (issue_i.op1),
      .op2_i (issue_i.op2),
      .opc_i (issue_i.opc.lu),               // LU view of opcode
      .res_o (lu_res)
   );

   ieu_mu mu (
      .clk               (clk),
      .rst_i             (rst_i),
      .start_i           (issue_valid_i & is_mem),
      .issue_i           (issue_i),
      .dbus_req_valid_o  (dbus_req_valid_o),
      .dbus_req_o        (dbus_req_o),
      .dbus_req_ready_i  (dbus_req_ready_i),
      .dbus_resp_valid_i (dbus_resp_valid_i),
      .dbus_resp_data_i  (dbus_resp_data_i),
      .done_o            (mu_done),
      .load_data_o       (mu_load_data)
   );

   // Address of the insn after the jump
   assign link_addr = DW'({issue_i.insn_pc + 1'b1, 2'b00});

   always_comb begin
      if (issue_i.jmplink) begin
         wb_data = link_addr;
      end else begin
         case (issue_i.fu)
            FU_AU:   wb_data = au_res;
            FU_LU:   wb_data = lu_res;
            FU_MU:   wb_data = mu_load_data;
            default: wb_data = '0;
         endcase
      end
   end

   // Memory insns commit on response, the rest at issue
   assign commit        = is_mem ? mu_done : issue_valid_i;
   assign issue_ready_o = ~is_mem | mu_done;

   assign regf_we_o      = commit & issue_i.wb_regf;
   assign regf_wr_o.addr = issue_i.wb_reg_addr;
   assign regf_wr_o.data = wb_data;

   // Far jump target arrives in op1 as a word address
   assign mispredict =
      (issue_i.specul_jmprel & (issue_i.specul_bcc != msr_psr_cc_i)) |
      (issue_i.specul_jmpfar & (issue_i.specul_tgt != issue_i.op1[PC_W-1:0]));

   assign flush_o     = commit & is_branch & mispredict;
   assign flush_tgt_o = issue_i.specul_jmprel ? issue_i.specul_tgt
                                              : issue_i.op1[PC_W-1:0];

   // Predictor training, once per committed branch
   assign bpu_upd_valid_o   = commit & is_branch;
   assign bpu_upd_o.jmprel  = issue_i.specul_jmprel;
   assign bpu_upd_o.insn_pc = issue_i.insn_pc;
   assign bpu_upd_o.hit     = ~flush_o;

endmodule

// ==== hdl/dmem.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data memory
// Word array, answers after MEM_LAT cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module dmem
   import ieu_cfg_pkg::*, ieu_op_pkg::*;
#(
   parameter int DEPTH   = 256,              // Words
   parameter int MEM_LAT = 2                 // Accept to response, at least 1
) (
   input  logic          clk,
   input  logic          rst_i,
   input  logic          req_valid_i,
   input  dbus_req_t     req_i,
   output logic          req_ready_o,
   output logic          resp_valid_o,
   output logic [DW-1:0] resp_data_o
);

   localparam int IDX_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(MEM_LAT + 1);

   logic [DW-1:0]    mem [DEPTH];
   logic [DW-1:0]    rdata_q;
   logic             busy_q;
   logic [CNT_W-1:0] cnt_q;                  // Cycles left to response
   logic             accept;
   logic [IDX_W-1:0] idx;
   logic [BE_W-1:0]  be_base;
   logic [BE_W-1:0]  be;

   assign req_ready_o = ~busy_q;
   assign accept      = req_valid_i & ~busy_q;
   assign idx         = req_i.addr[LANE_AW +: IDX_W];   // Upper bits wrap

   // Lane mask from access width, then moved to the byte offset
   always_comb begin
      case (req_i.size)
         SZ_BYTE: be_base = BE_W'(1);
         SZ_HALF: be_base = BE_W'(3);
         default: be_base = '1;
      endcase
   end
   assign be = be_base << req_i.addr[LANE_AW-1:0];

   always_ff @(posedge clk) begin
      if (rst_i) begin
         busy_q <= 1'b0;
         cnt_q  <= '0;
      end else if (accept) begin
         busy_q <= 1'b1;
         cnt_q  <= CNT_W'(MEM_LAT);
      end else if (busy_q) begin
         cnt_q <= cnt_q - 1'b1;
         if (cnt_q == CNT_W'(1)) busy_q <= 1'b0;   // Last cycle of access
      end
   end

   assign resp_valid_o = busy_q & (cnt_q == CNT_W'(1));

   // Read before write, store response data is don't care
   always_ff @(posedge clk) begin
      if (accept) begin
         rdata_q <= mem[idx];
         if (req_i.we) begin
            for (int i = 0; i < BE_W; i++) begin
               if (be[i]) mem[idx][i*8 +: 8] <= req_i.wdata[i*8 +: 8];
            end
         end
      end
   end

   assign resp_data_o = rdata_q;             // Held until next accept

endmodule

// ==== hdl/ieu_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IEU top
// Execution stage joined to data memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module ieu_top
   import ieu_cfg_pkg::*, ieu_op_pkg::*;
#(
   parameter int MEM_LAT = 2,
   parameter int DEPTH   = 256
) (
   input  logic            clk,
   input  logic            rst_i,
   input  logic            issue_valid_i,
   input  issue_t          issue_i,
   output logic            issue_ready_o,
   input  logic            msr_psr_cc_i,
   output logic            regf_we_o,
   output regf_wr_t        regf_wr_o,
   output logic            flush_o,
   output logic [PC_W-1:0] flush_tgt_o,
   output logic            bpu_upd_valid_o,
   output bpu_upd_t        bpu_upd_o
);

   // Internal data bus
   logic          dbus_req_valid;
   dbus_req_t     dbus_req;
   logic          dbus_req_ready;
   logic          dbus_resp_valid;          // No ready, always taken
   logic [DW-1:0] dbus_resp_data;

   ieu ieu0 (
      .clk               (clk),
      .rst_i             (rst_i),
      .issue_valid_i     (issue_valid_i),
      .issue_i           (issue_i),
      .issue_ready_o     (issue_ready_o),
      .msr_psr_cc_i      (msr_psr_cc_i),
      .regf_we_o         (regf_we_o),
      .regf_wr_o         (regf_wr_o),
      .flush_o           (flush_o),
      .flush_tgt_o       (flush_tgt_o),
      .bpu_upd_valid_o   (bpu_upd_valid_o),
      .bpu_upd_o         (bpu_upd_o),
      .dbus_req_valid_o  (dbus_req_valid),
      .dbus_req_o        (dbus_req),
      .dbus_req_ready_i  (dbus_req_ready),
      .dbus_resp_valid_i (dbus_resp_valid),
      .dbus_resp_data_i  (dbus_resp_data)
   );

   dmem #(
      .DEPTH   (DEPTH),
      .MEM_LAT (MEM_LAT)
   ) dmem0 (
      .clk          (clk),
      .rst_i        (rst_i),
      .req_valid_i  (dbus_req_valid),
      .req_i        (dbus_req),
      .req_ready_o  (dbus_req_ready),
      .resp_valid_o (dbus_resp_valid),
      .resp_data_o  (dbus_resp_data)
   );

endmodule

// ==== dv/ieu_asserts.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory unit bus checks
// Request hold, response pairing, done pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module ieu_asserts
   import ieu_cfg_pkg::*, ieu_op_pkg::*;
(
   input logic      clk,
   input logic      rst_i,
   input logic      req_valid_i,
   input dbus_req_t req_i,
   input logic      req_ready_i,
   input logic      resp_valid_i,
   input logic      done_i
);

   logic outstanding_q;                      // Accepted, no response yet

   always_ff @(posedge clk) begin
      if (rst_i) outstanding_q <= 1'b0;
      else if (req_valid_i & req_ready_i) outstanding_q <= 1'b1;
      else if (resp_valid_i) outstanding_q <= 1'b0;
   end

   // Held request must not move
   req_stable: assert property (@(posedge clk) disable iff (rst_i)
      req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
      else $error("Bus request changed or dropped before it was accepted");

   resp_has_req: assert property (@(posedge clk) disable iff (rst_i)
      resp_valid_i |-> outstanding_q)
      else $error("Bus response seen with no outstanding request");

   // One cycle only
   done_pulse: assert property (@(posedge clk) disable iff (rst_i)
      done_i |=> !done_i)
      else $error("Memory unit done held for more than one cycle");

endmodule

bind ieu_mu ieu_asserts asserts0 (
   .clk          (clk),
   .rst_i        (rst_i),
   .req_valid_i  (dbus_req_valid_o),
   .req_i        (dbus_req_o),
   .req_ready_i  (dbus_req_ready_i),
   .resp_valid_i (dbus_resp_valid_i),
   .done_i       (done_o)
);

// ==== dv/ieu_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IEU testbench
// Issues stim file instructions, checks all results
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module ieu_tb
   import ieu_cfg_pkg::*, ieu_op_pkg::*;
();

   localparam int MEM_LAT    = 2;
   localparam int RST_CYCLES = 16;
   localparam int MAX_REC    = 64;
   localparam int NF         = 22;          // Words per stim record

   // Field offsets inside one record
   localparam int F_FU = 0, F_OPC = 1, F_LD = 2, F_ST = 3, F_SZ = 4;
   localparam int F_OP1 = 5, F_OP2 = 6, F_OP3 = 7, F_WB = 8, F_RD = 9;
   localparam int F_PC = 10, F_JL = 11, F_JREL = 12, F_JFAR = 13, F_BCC = 14;
   localparam int F_TGT = 15, F_CC = 16;
   localparam int F_EWE = 17, F_EDATA = 18, F_EFL = 19, F_ETGT = 20, F_EHIT = 21;

   typedef struct packed {
      logic            we;
      logic [DW-1:0]   data;
      logic            fl;
      logic [PC_W-1:0] tgt;
      logic            hit;
   } expect_t;

   logic            clk;
   logic            rst_i;
   logic            issue_valid_i;
   issue_t          issue_i;
   logic            issue_ready_o;
   logic            msr_psr_cc_i;
   logic            regf_we_o;
   regf_wr_t        regf_wr_o;
   logic            flush_o;
   logic [PC_W-1:0] flush_tgt_o;
   logic            bpu_upd_valid_o;
   bpu_upd_t        bpu_upd_o;

   logic [31:0] stim [NF*MAX_REC];
   int          n_rec;
   int          errors      = 0;
   int          cycles      = 0;
   int          cycle_limit = 1000;

   ieu_top #(
      .MEM_LAT (MEM_LAT),
      .DEPTH   (256)
   ) dut0 (
      .clk             (clk),
      .rst_i           (rst_i),
      .issue_valid_i   (issue_valid_i),
      .issue_i         (issue_i),
      .issue_ready_o   (issue_ready_o),
      .msr_psr_cc_i    (msr_psr_cc_i),
      .regf_we_o       (regf_we_o),
      .regf_wr_o       (regf_wr_o),
      .flush_o         (flush_o),
      .flush_tgt_o     (flush_tgt_o),
      .bpu_upd_valid_o (bpu_upd_valid_o),
      .bpu_upd_o       (bpu_upd_o)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;               // 100 ns period
   end

   // Hang guard
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("Timeout: DUT did not complete the run within %0d cycles", cycle_limit);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
      assert (got === exp) else begin
         errors++;
         $display("ERROR t=%0t %s exp %08h got %08h", $time, name, exp, got);
      end
   endtask

   // No commit side effects outside a completing cycle
   task automatic check_idle();
      check_value("regf_we_o", 32'h0, 32'(regf_we_o));
      check_value("flush_o", 32'h0, 32'(flush_o));
      check_value("bpu_upd_valid_o", 32'h0, 32'(bpu_upd_valid_o));
   endtask

   function automatic issue_t make_issue(input int r);
      issue_t iss;
      int     b;
      b = r * NF;
      iss               = '0;
      iss.fu            = fu_e'(stim[b+F_FU][1:0]);
      iss.opc           = opc_u'(stim[b+F_OPC][2:0]);
      iss.mem_load      = stim[b+F_LD][0];
      iss.mem_store     = stim[b+F_ST][0];
      iss.mem_size      = mem_size_e'(stim[b+F_SZ][2:0]);
      iss.op1           = stim[b+F_OP1];
      iss.op2           = stim[b+F_OP2];
      iss.op3           = stim[b+F_OP3];
      iss.wb_regf       = stim[b+F_WB][0];
      iss.wb_reg_addr   = stim[b+F_RD][REG_AW-1:0];
      iss.insn_pc       = stim[b+F_PC][PC_W-1:0];
      iss.jmplink       = stim[b+F_JL][0];
      iss.specul_jmprel = stim[b+F_JREL][0];
      iss.specul_jmpfar = stim[b+F_JFAR][0];
      iss.specul_bcc    = stim[b+F_BCC][0];
      iss.specul_tgt    = stim[b+F_TGT][PC_W-1:0];
      return iss;
   endfunction

   function automatic expect_t make_expect(input int r);
      expect_t e;
      int      b;
      b = r * NF;
      e.we   = stim[b+F_EWE][0];
      e.data = stim[b+F_EDATA];
      e.fl   = stim[b+F_EFL][0];
      e.tgt  = stim[b+F_ETGT][PC_W-1:0];
      e.hit  = stim[b+F_EHIT][0];
      return e;
   endfunction

   // Outputs in the completing cycle
   task automatic check_commit(input issue_t iss, input expect_t e);
      logic branch;
      branch = iss.specul_jmprel | iss.specul_jmpfar;
      check_value("regf_we_o", 32'(e.we), 32'(regf_we_o));
      if (e.we) begin
         check_value("regf_wr_o.addr", 32'(iss.wb_reg_addr), 32'(regf_wr_o.addr));
         check_value("regf_wr_o.data", e.data, regf_wr_o.data);
      end
      check_value("flush_o", 32'(e.fl), 32'(flush_o));
      if (e.fl) check_value("flush_tgt_o", 32'(e.tgt), 32'(flush_tgt_o));
      check_value("bpu_upd_valid_o", 32'(branch), 32'(bpu_upd_valid_o));
      if (branch) begin
         check_value("bpu_upd_o.hit", 32'(e.hit), 32'(bpu_upd_o.hit));
         check_value("bpu_upd_o.insn_pc", 32'(iss.insn_pc), 32'(bpu_upd_o.insn_pc));
         check_value("bpu_upd_o.jmprel", 32'(iss.specul_jmprel), 32'(bpu_upd_o.jmprel));
      end
   endtask

   initial begin
      issue_t  iss;
      expect_t e;
      int      gap;
      int      low_cycles;
      int      exp_low;
      rst_i         = 1'b1;
      issue_valid_i = 1'b0;
      issue_i       = '0;
      msr_psr_cc_i  = 1'b0;
      void'($urandom(32'hb953b122));
      // Fill marks unread words, always above any fu code
      for (int i = 0; i < NF*MAX_REC; i++) stim[i] = 32'hF000_0000 | 32'(i);
      $readmemh("dv/ieu_stim.txt", stim);
      n_rec = 0;
      while (n_rec < MAX_REC && stim[n_rec*NF+F_FU] <= 32'd3) n_rec++;
      if (n_rec == 0) begin
         errors++;
         $display("Stim file holds no instructions");
      end else if (stim[(n_rec-1)*NF+F_EHIT] > 32'd1) begin
         errors++;
         $display("Last stim record is incomplete");
      end
      cycle_limit = n_rec * (MEM_LAT + 6) + RST_CYCLES + 8;

      repeat (RST_CYCLES) @(posedge clk);
      rst_i <= 1'b0;
      @(negedge clk);
      check_idle();

      for (int r = 0; r < n_rec; r++) begin
         iss = make_issue(r);
         e   = make_expect(r);
         gap = $urandom_range(3, 0);
         @(posedge clk);
         issue_valid_i <= 1'b0;
         repeat (gap) begin
            @(negedge clk);
            check_idle();
            @(posedge clk);
         end
         issue_valid_i <= 1'b1;
         issue_i       <= iss;
         msr_psr_cc_i  <= stim[r*NF+F_CC][0];
         exp_low    = (iss.mem_load | iss.mem_store) ? MEM_LAT + 1 : 0;
         low_cycles = 0;
         @(negedge clk);
         while (!issue_ready_o) begin       // Memory access in flight
            check_idle();
            low_cycles++;
            @(negedge clk);
         end
         check_value("issue_ready_o low cycles", 32'(exp_low), 32'(low_cycles));
         check_commit(iss, e);
      end
      @(posedge clk);
      issue_valid_i <= 1'b0;
      repeat (2) begin
         @(negedge clk);
         check_idle();
      end

      $display("Run finished: %0d instructions, %0d errors", n_rec, errors);
      if (errors == 0) $display("ALL CHECKS PASSED");
      else $display("CHECKS FAILED");
      $finish;
   end

endmodule

// ==== dv/ieu_stim.txt ====
// fu opc ld st sz op1 op2 op3 wb rd pc jl jrel jfar bcc tgt cc
// then expected: regf_we data flush flush_tgt bpu_hit, all hex
// Arithmetic
1 0 0 0 0 00000005 00000003 00000000 1 01 0010 0 0 0 0 0000 0 1 00000008 0 0000 0
1 1 0 0 0 00000003 00000005 00000000 1 02 0011 0 0 0 0 0000 0 1 FFFFFFFE 0 0000 0
1 2 0 0 0 00012345 00000100 00000000 1 03 0012 0 0 0 0 0000 0 1 01234500 0 0000 0
1 2 0 0 0 00010000 00010003 00000000 1 04 0013 0 0 0 0 0000 0 1 00030000 0 0000 0
1 0 0 0 0 00000001 00000001 00000000 0 05 0014 0 0 0 0 0000 0 0 00000000 0 0000 0
// Logic and shifts
2 0 0 0 0 F0F0F0F0 FF00FF00 00000000 1 06 0015 0 0 0 0 0000 0 1 F000F000 0 0000 0
2 1 0 0 0 F0F0F0F0 FF00FF00 00000000 1 07 0016 0 0 0 0 0000 0 1 FFF0FFF0 0 0000 0
2 2 0 0 0 F0F0F0F0 FF00FF00 00000000 1 08 0017 0 0 0 0 0000 0 1 0FF00FF0 0 0000 0
2 3 0 0 0 000000FF 00000024 00000000 1 09 0018 0 0 0 0 0000 0 1 00000FF0 0 0000 0
2 3 0 0 0 00000001 0000001F 00000000 1 0A 0019 0 0 0 0 0000 0 1 80000000 0 0000 0
2 4 0 0 0 80000000 0000001F 00000000 1 0B 001A 0 0 0 0 0000 0 1 00000001 0 0000 0
2 5 0 0 0 80000000 00000004 00000000 1 0C 001B 0 0 0 0 0000 0 1 F8000000 0 0000 0
2 5 0 0 0 7FFFFFFF 00000010 00000000 1 0D 001C 0 0 0 0 0000 0 1 00007FFF 0 0000 0
// Stores, then loads of the merged words
0 0 0 1 4 00000100 00000000 11223344 0 00 0020 0 0 0 0 0000 0 0 00000000 0 0000 0
0 0 0 1 4 00000100 00000004 AABBCCDD 0 00 0021 0 0 0 0 0000 0 0 00000000 0 0000 0
0 0 0 1 1 00000100 00000001 FFFFFFEE 0 00 0022 0 0 0 0 0000 0 0 00000000 0 0000 0
0 0 0 1 2 00000104 00000002 12345566 0 00 0023 0 0 0 0 0000 0 0 00000000 0 0000 0
3 0 1 0 4 00000100 00000000 00000000 1 10 0024 0 0 0 0 0000 0 1 1122EE44 0 0000 0
3 0 1 0 1 00000100 00000001 00000000 1 11 0025 0 0 0 0 0000 0 1 000000EE 0 0000 0
3 0 1 0 1 00000100 00000003 00000000 1 12 0026 0 0 0 0 0000 0 1 00000011 0 0000 0
3 0 1 0 2 00000100 00000002 00000000 1 13 0027 0 0 0 0 0000 0 1 00001122 0 0000 0
3 0 1 0 2 00000104 00000002 00000000 1 14 0028 0 0 0 0 0000 0 1 00005566 0 0000 0
3 0 1 0 4 00000104 00000000 00000000 1 15 0029 0 0 0 0 0000 0 1 5566CCDD 0 0000 0
3 0 1 0 1 00000104 00000000 00000000 1 16 002A 0 0 0 0 0000 0 1 000000DD 0 0000 0
3 0 1 0 2 00000100 00000000 00000000 1 17 002B 0 0 0 0 0000 0 1 0000EE44 0 0000 0
// Jump-and-link
0 0 0 0 0 00000000 00000000 00000000 1 1F 0FFF 1 0 0 0 0000 0 1 00004000 0 0000 0
0 0 0 0 0 00000200 00000000 00000000 1 1E 0040 1 0 1 0 0200 0 1 00000104 0 0000 1
// Relative branches and far jumps
0 0 0 0 0 00000000 00000000 00000000 0 00 0050 0 1 0 1 0123 1 0 00000000 0 0000 1
0 0 0 0 0 00000000 00000000 00000000 0 00 0051 0 1 0 1 0123 0 0 00000000 1 0123 0
0 0 0 0 0 00000000 00000000 00000000 0 00 0052 0 1 0 0 0077 1 0 00000000 1 0077 0
0 0 0 0 0 00000000 00000000 00000000 0 00 0053 0 1 0 0 0077 0 0 00000000 0 0000 1
0 0 0 0 0 00000300 00000000 00000000 0 00 0060 0 0 1 0 0300 0 0 00000000 0 0000 1
0 0 0 0 0 00000400 00000000 00000000 0 00 0061 0 0 1 0 0300 0 0 00000000 1 0400 0

// ==== sim.f ====
common/ieu_cfg_pkg.sv
common/ieu_op_pkg.sv
hdl/ieu_au.sv
hdl/ieu_lu.sv
ieu/ieu_mu.sv
ieu/ieu.sv
hdl/dmem.sv
hdl/ieu_top.sv
dv/ieu_asserts.sv
dv/ieu_tb.sv

// ==== Makefile ====
TOP := ieu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

lint:
	verilator --lint-only --timing --assert -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir
